// File: Makefile
VERILATOR  ?= verilator
TOP        := rv_exec_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
SIM_ARGS   := +verilator+error+limit+100
FAIL_MSG   := RESULT: FAIL
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/alu.sv
module alu (
    input  logic [rv_exec_pkg::xlen-1:0]      src1,
    input  logic [rv_exec_pkg::xlen-1:0]      src2,
    input  logic [rv_exec_pkg::alu_op_w-1:0]  alu_op,
    output logic [rv_exec_pkg::xlen-1:0]      alu_result
);
    import rv_exec_pkg::*;

    logic               use_sub;
    logic               carry;
    logic [xlen-1:0]    adder_b;
    logic [xlen-1:0]    sum;
    logic [shamt_w-1:0] shamt;
    logic               lt_u;
    logic               lt_s;
    logic               is_zero;
    logic [xlen-1:0]    sltu_res;
    logic [xlen-1:0]    slt_res;
    logic [xlen-1:0]    beq_res;
    logic [xlen-1:0]    bne_res;
    logic [xlen-1:0]    sll_res;
    logic [xlen-1:0]    srl_res;
    logic [xlen-1:0]    sra_res;

    // subtract path shared by sub, compares and branches
    assign use_sub = alu_op[alu_sub] | alu_op[alu_slt] | alu_op[alu_sltu]
                   | alu_op[alu_beq] | alu_op[alu_bne];
    assign adder_b = use_sub ? ~src2 : src2;
    assign {carry, sum} = {1'b0, src1} + {1'b0, adder_b} + {{xlen{1'b0}}, use_sub};

    // no carry out means borrow
    assign lt_u    = ~carry;
    assign lt_s    = (src1[xlen-1] != src2[xlen-1]) ? src1[xlen-1] : sum[xlen-1];
    assign is_zero = (sum == '0);

    assign sltu_res = {{(xlen-1){1'b0}}, lt_u};
    assign slt_res  = {{(xlen-1){1'b0}}, lt_s};
    assign beq_res  = {{(xlen-1){1'b0}}, is_zero};
    assign bne_res  = {{(xlen-1){1'b0}}, ~is_zero};

    assign shamt   = src2[shamt_w-1:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;

    assign alu_result = ({xlen{alu_op[alu_add] | alu_op[alu_sub]}} & sum)
                      | ({xlen{alu_op[alu_sltu]}} & sltu_res)
                      | ({xlen{alu_op[alu_slt]}}  & slt_res)
                      | ({xlen{alu_op[alu_beq]}}  & beq_res)
                      | ({xlen{alu_op[alu_bne]}}  & bne_res)
                      | ({xlen{alu_op[alu_xor]}}  & (src1 ^ src2))
                      | ({xlen{alu_op[alu_or]}}   & (src1 | src2))
                      | ({xlen{alu_op[alu_and]}}  & (src1 & src2))
                      | ({xlen{alu_op[alu_sll]}}  & sll_res)
                      | ({xlen{alu_op[alu_srl]}}  & srl_res)
                      | ({xlen{alu_op[alu_sra]}}  & sra_res);

endmodule

// File: source/apb_cmd_port.sv
module apb_cmd_port (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [rv_exec_pkg::apb_addr_w-1:0]  paddr,
    input  logic [rv_exec_pkg::xlen-1:0]        pwdata,
    output logic [rv_exec_pkg::xlen-1:0]        prdata,
    output logic                                pready,
    output logic                                pslverr,
    exec_if.port                                cmd
);
    import rv_exec_pkg::*;

    logic                  access;
    logic                  sel_instr;
    logic                  sel_status;
    logic                  sel_win;
    logic                  s1_full;
    logic                  busy_next;
    logic [apb_addr_w-1:0] win_off;
    logic [xlen-1:0]       status_word;

    assign access     = psel & penable;
    assign win_off    = paddr - addr_reg_base;
    assign sel_instr  = (paddr == addr_instr);
    assign sel_status = (paddr == addr_status);
    assign sel_win    = (paddr >= addr_reg_base) && (win_off < reg_win_bytes)
                        && (paddr[1:0] == 2'b00);

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access) begin
            if (pwrite && sel_instr) begin
                // hold off while stage one is occupied
                pready = !s1_full;
            end else if (!pwrite && (sel_status || sel_win)) begin
                pready = !cmd.busy;
            end else begin
                pready = 1'b1;
            end
            if (pwrite) begin
                pslverr = pready && !(sel_instr || sel_status);
            end else begin
                pslverr = pready && !(sel_status || sel_win);
            end
        end
    end

    assign cmd.dbg_idx       = win_off[reg_idx_w+1:2];
    assign cmd.issue_instr   = pwdata;
    assign cmd.issue_valid   = pready & pwrite & sel_instr;
    assign cmd.illegal_clear = pready & pwrite & sel_status & pwdata[st_illegal];

    // busy as it will be after this edge
    assign busy_next = cmd.issue_valid | s1_full;

    always_comb begin
        status_word = '0;
        status_word[st_busy]    = busy_next;
        status_word[st_taken]   = cmd.taken;
        status_word[st_illegal] = cmd.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_full <= 1'b0;
        end else begin
            s1_full <= cmd.issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (psel && !pwrite) begin
            prdata <= sel_status ? status_word : cmd.dbg_data;
        end
    end

endmodule

// File: source/exec_if.sv
interface exec_if;
    import rv_exec_pkg::*;

    logic                 issue_valid;
    logic [xlen-1:0]      issue_instr;
    logic                 busy;
    logic [reg_idx_w-1:0] dbg_idx;
    logic [xlen-1:0]      dbg_data;
    logic                 taken;
    logic                 illegal;
    logic                 illegal_clear;

    // apb command side
    modport port (
        output issue_valid,
        output issue_instr,
        output dbg_idx,
        output illegal_clear,
        input  busy,
        input  dbg_data,
        input  taken,
        input  illegal
    );

    modport pipe (
        input  issue_valid,
        input  issue_instr,
        input  dbg_idx,
        input  illegal_clear,
        output busy,
        output dbg_data,
        output taken,
        output illegal
    );

endinterface

// File: source/exec_pipe.sv
module exec_pipe (
    input  logic  clk,
    input  logic  reset,
    exec_if.pipe  cmd
);
    import rv_exec_pkg::*;

    logic                 s1_valid;
    logic [xlen-1:0]      s1_instr;
    logic [alu_op_w-1:0]  alu_op;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      imm;
    logic                 use_imm;
    logic                 writes_rd;
    logic                 is_branch;
    logic                 illegal;
    logic [xlen-1:0]      rdata_a;
    logic [xlen-1:0]      rdata_b;
    logic [xlen-1:0]      rdata_dbg;
    logic [xlen-1:0]      op_a;
    logic [xlen-1:0]      op_b;
    logic [xlen-1:0]      alu_result;
    logic                 s2_valid;
    logic                 s2_we;
    logic                 s2_branch;
    logic                 s2_illegal;
    logic [reg_idx_w-1:0] s2_rd;
    logic [xlen-1:0]      s2_result;
    logic                 taken_q;
    logic                 illegal_q;

    instr_decode instr_decode_inst (
        .instr     (s1_instr),
        .alu_op    (alu_op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .writes_rd (writes_rd),
        .is_branch (is_branch),
        .illegal   (illegal)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .reset     (reset),
        .we        (s2_we),
        .waddr     (s2_rd),
        .raddr_a   (rs1),
        .raddr_b   (rs2),
        .raddr_dbg (cmd.dbg_idx),
        .wdata     (s2_result),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .rdata_dbg (rdata_dbg)
    );

    // forward from stage two on a matching nonzero rd
    assign op_a = (s2_we && (s2_rd == rs1) && (rs1 != '0)) ? s2_result : rdata_a;
    assign op_b = (s2_we && (s2_rd == rs2) && (rs2 != '0)) ? s2_result : rdata_b;

    alu alu_inst (
        .src1       (op_a),
        .src2       (use_imm ? imm : op_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            s2_we      <= 1'b0;
            s2_branch  <= 1'b0;
            s2_illegal <= 1'b0;
            taken_q    <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            s1_valid   <= cmd.issue_valid;
            s2_valid   <= s1_valid;
            s2_we      <= s1_valid & writes_rd;
            s2_branch  <= s1_valid & is_branch;
            s2_illegal <= s1_valid & illegal;
            if (s2_branch) begin
                taken_q <= s2_result[0];
            end
            // a new illegal wins over a clear
            if (s2_illegal) begin
                illegal_q <= 1'b1;
            end else if (cmd.illegal_clear) begin
                illegal_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.issue_valid) begin
            s1_instr <= cmd.issue_instr;
        end
        if (s1_valid) begin
            s2_rd     <= rd;
            s2_result <= alu_result;
        end
    end

    assign cmd.busy = s1_valid | s2_valid;

    // debug view includes the pending stage two commit
    assign cmd.dbg_data = (s2_we && (s2_rd == cmd.dbg_idx)) ? s2_result : rdata_dbg;
    assign cmd.taken    = s2_branch ? s2_result[0] : taken_q;
    assign cmd.illegal  = illegal_q | s2_illegal;

endmodule

// File: source/instr_decode.sv
module instr_decode (
    input  rv_exec_pkg::instr_word_t               instr,
    output logic [rv_exec_pkg::alu_op_w-1:0]       alu_op,
    output logic [rv_exec_pkg::reg_idx_w-1:0]      rs1,
    output logic [rv_exec_pkg::reg_idx_w-1:0]      rs2,
    output logic [rv_exec_pkg::reg_idx_w-1:0]      rd,
    output logic [rv_exec_pkg::xlen-1:0]           imm,
    output logic                                   use_imm,
    output logic                                   writes_rd,
    output logic                                   is_branch,
    output logic                                   illegal
);
    import rv_exec_pkg::*;

    always_comb begin
        alu_op  = '0;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = '0;
        use_imm = 1'b0;
        case (instr.r_view.opcode)
            opc_op: begin
                rs1 = instr.r_view.rs1;
                rs2 = instr.r_view.rs2;
                rd  = instr.r_view.rd;
                if (instr.r_view.funct7 == f7_base) begin
                    case (instr.r_view.funct3)
                        3'b000: alu_op[alu_add]  = 1'b1;
                        3'b001: alu_op[alu_sll]  = 1'b1;
                        3'b010: alu_op[alu_slt]  = 1'b1;
                        3'b011: alu_op[alu_sltu] = 1'b1;
                        3'b100: alu_op[alu_xor]  = 1'b1;
                        3'b101: alu_op[alu_srl]  = 1'b1;
                        3'b110: alu_op[alu_or]   = 1'b1;
                        3'b111: alu_op[alu_and]  = 1'b1;
                    endcase
                end else if (instr.r_view.funct7 == f7_alt) begin
                    case (instr.r_view.funct3)
                        3'b000:  alu_op[alu_sub] = 1'b1;
                        3'b101:  alu_op[alu_sra] = 1'b1;
                        default: ;
                    endcase
                end
            end
            opc_op_imm: begin
                rs1     = instr.i_view.rs1;
                rd      = instr.i_view.rd;
                use_imm = 1'b1;
                imm     = {{(xlen-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};
                case (instr.i_view.funct3)
                    3'b000: alu_op[alu_add]  = 1'b1;
                    3'b010: alu_op[alu_slt]  = 1'b1;
                    3'b011: alu_op[alu_sltu] = 1'b1;
                    3'b100: alu_op[alu_xor]  = 1'b1;
                    3'b110: alu_op[alu_or]   = 1'b1;
                    3'b111: alu_op[alu_and]  = 1'b1;
                    3'b001: begin
                        imm = {{(xlen-shamt_w){1'b0}}, instr.i_view.imm12[shamt_w-1:0]};
                        alu_op[alu_sll] = (instr.i_view.imm12[11:5] == f7_base);
                    end
                    3'b101: begin
                        // srai is told apart by imm[10]
                        imm = {{(xlen-shamt_w){1'b0}}, instr.i_view.imm12[shamt_w-1:0]};
                        alu_op[alu_srl] = (instr.i_view.imm12[11:5] == f7_base);
                        alu_op[alu_sra] = (instr.i_view.imm12[11:5] == f7_alt);
                    end
                endcase
            end
            opc_branch: begin
                rs1 = instr.b_view.rs1;
                rs2 = instr.b_view.rs2;
                case (instr.b_view.funct3)
                    3'b000:  alu_op[alu_beq] = 1'b1;
                    3'b001:  alu_op[alu_bne] = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign illegal   = (alu_op == '0);
    assign is_branch = (instr.b_view.opcode == opc_branch) && !illegal;
    // x0 writes are dropped here
    assign writes_rd = !illegal && !is_branch && (rd != '0);

endmodule

// File: source/reg_file.sv
module reg_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               we,
    input  logic [rv_exec_pkg::reg_idx_w-1:0]  waddr,
    input  logic [rv_exec_pkg::reg_idx_w-1:0]  raddr_a,
    input  logic [rv_exec_pkg::reg_idx_w-1:0]  raddr_b,
    input  logic [rv_exec_pkg::reg_idx_w-1:0]  raddr_dbg,
    input  logic [rv_exec_pkg::xlen-1:0]       wdata,
    output logic [rv_exec_pkg::xlen-1:0]       rdata_a,
    output logic [rv_exec_pkg::xlen-1:0]       rdata_b,
    output logic [rv_exec_pkg::xlen-1:0]       rdata_dbg
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata_a   = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b   = (raddr_b == '0) ? '0 : regs[raddr_b];
    assign rdata_dbg = (raddr_dbg == '0) ? '0 : regs[raddr_dbg];

endmodule

// File: source/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w = 5;
    localparam int apb_addr_w = 12;
    localparam int alu_op_w = 12;

    // one-hot alu select positions
    localparam int alu_add  = 0;
    localparam int alu_sltu = 1;
    localparam int alu_bne  = 2;
    localparam int alu_xor  = 3;
    localparam int alu_or   = 4;
    localparam int alu_sub  = 5;
    localparam int alu_sra  = 6;
    localparam int alu_sll  = 7;
    localparam int alu_and  = 8;
    localparam int alu_slt  = 9;
    localparam int alu_beq  = 10;
    localparam int alu_srl  = 11;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000;

    // apb register map
    localparam logic [apb_addr_w-1:0] addr_instr    = 12'h000;
    localparam logic [apb_addr_w-1:0] addr_status   = 12'h004;
    localparam logic [apb_addr_w-1:0] addr_reg_base = 12'h080;
    localparam logic [apb_addr_w-1:0] reg_win_bytes = apb_addr_w'(4 * reg_count);

    localparam int st_busy    = 0;
    localparam int st_taken   = 1;
    localparam int st_illegal = 2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } b_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        b_view_t b_view;
    } instr_word_t;

endpackage

// File: source/rv_exec_top.sv
module rv_exec_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [rv_exec_pkg::apb_addr_w-1:0]  paddr,
    input  logic [rv_exec_pkg::xlen-1:0]        pwdata,
    output logic [rv_exec_pkg::xlen-1:0]        prdata,
    output logic                                pready,
    output logic                                pslverr
);

    exec_if cmd_if ();

    apb_cmd_port apb_cmd_port_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd_if.port)
    );

    exec_pipe exec_pipe_inst (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_if.pipe)
    );

endmodule

// File: sources.f
source/rv_exec_pkg.sv
source/exec_if.sv
source/alu.sv
source/reg_file.sv
source/instr_decode.sv
source/exec_pipe.sv
source/apb_cmd_port.sv
source/rv_exec_top.sv
testbench/rv_exec_assertions.sv
testbench/rv_exec_tb.sv

// File: testbench/rv_exec_assertions.sv
module rv_exec_assertions (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [rv_exec_pkg::apb_addr_w-1:0]  paddr,
    input  logic [rv_exec_pkg::xlen-1:0]        pwdata,
    input  logic [rv_exec_pkg::xlen-1:0]        prdata,
    input  logic                                pready,
    input  logic                                pslverr,
    input  logic                                busy
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv_exec_pkg::*;

    logic [xlen-1:0] shadow [reg_count];
    logic            shadow_taken;
    logic            shadow_illegal;
    logic            done;
    logic            sel_instr;
    logic            sel_status;
    logic            sel_window;
    logic            expect_err;
    logic [xlen-1:0] expect_read;
    instr_word_t     word;
    logic            legal;
    logic            branch;
    logic            alt;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] result;
    int              fail_count = 0;

    function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic sub_shift,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (f3)
            3'd0:    return sub_shift ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return sub_shift ? xlen'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    assign done       = psel && penable && pready;
    assign sel_instr  = (paddr == addr_instr);
    assign sel_status = (paddr == addr_status);
    // 32 words from 0x080
    assign sel_window = (paddr[11:7] == 5'b00001) && (paddr[1:0] == 2'b00);
    assign expect_err = pwrite ? !(sel_instr || sel_status) : !(sel_status || sel_window);

    always_comb begin
        if (sel_status) begin
            expect_read = {29'b0, shadow_illegal, shadow_taken, 1'b0};
        end else begin
            expect_read = shadow[paddr[6:2]];
        end
    end

    // reference execution of the word being written
    always_comb begin
        word   = pwdata;
        alt    = (word.r_view.funct7 == f7_alt);
        src_a  = shadow[word.r_view.rs1];
        src_b  = shadow[word.r_view.rs2];
        legal  = 1'b0;
        branch = 1'b0;
        result = '0;
        case (word.r_view.opcode)
            opc_op: begin
                legal = (word.r_view.funct7 == f7_base)
                        || (alt && (word.r_view.funct3 == 3'd0 || word.r_view.funct3 == 3'd5));
                result = alu_model(word.r_view.funct3, alt, src_a, src_b);
            end
            opc_op_imm: begin
                src_b = {{20{word.i_view.imm12[11]}}, word.i_view.imm12};
                legal = 1'b1;
                if (word.i_view.funct3 == 3'd1) begin
                    legal = (word.i_view.imm12[11:5] == f7_base);
                end else if (word.i_view.funct3 == 3'd5) begin
                    legal = (word.i_view.imm12[11:5] == f7_base)
                            || (word.i_view.imm12[11:5] == f7_alt);
                end
                result = alu_model(word.i_view.funct3,
                                   (word.i_view.funct3 == 3'd5) && word.i_view.imm12[10],
                                   src_a, src_b);
            end
            opc_branch: begin
                src_a  = shadow[word.b_view.rs1];
                src_b  = shadow[word.b_view.rs2];
                legal  = (word.b_view.funct3 == 3'd0) || (word.b_view.funct3 == 3'd1);
                branch = legal;
                result = {31'b0, (src_a == src_b) ^ word.b_view.funct3[0]};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                shadow[i] <= '0;
            end
            shadow_taken   <= 1'b0;
            shadow_illegal <= 1'b0;
        end else if (done && pwrite && sel_instr) begin
            if (!legal) begin
                shadow_illegal <= 1'b1;
            end else if (branch) begin
                shadow_taken <= result[0];
            end else if (word.r_view.rd != '0) begin
                shadow[word.r_view.rd] <= result;
            end
        end else if (done && pwrite && sel_status && pwdata[st_illegal]) begin
            shadow_illegal <= 1'b0;
        end
    end

    read_data_check: assert property (
        @(posedge clk) disable iff (reset)
        done && !pwrite && (sel_status || sel_window) |-> prdata == expect_read
    ) else begin
        fail_count++;
        $error("ERROR prdata at paddr %h: got %h, expected %h", $sampled(paddr),
               $sampled(prdata), $sampled(expect_read));
    end

    slverr_check: assert property (
        @(posedge clk) disable iff (reset)
        done |-> pslverr == expect_err
    ) else begin
        fail_count++;
        $error("ERROR pslverr at paddr %h: got %h, expected %h", $sampled(paddr),
               $sampled(pslverr), $sampled(expect_err));
    end

    idle_check: assert property (
        @(posedge clk) disable iff (reset)
        !(psel && penable) |-> !pready && !pslverr
    ) else begin
        fail_count++;
        $error("pready or pslverr raised outside an access phase");
    end

    // reads must not finish before the pipeline drains
    busy_stall_check: assert property (
        @(posedge clk) disable iff (reset)
        psel && penable && !pwrite && (sel_window || sel_status) && busy |-> !pready
    ) else begin
        fail_count++;
        $error("read completed while the pipeline was still busy");
    end

endmodule

bind rv_exec_top rv_exec_assertions rv_exec_assertions_inst (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (cmd_if.busy)
);

// File: testbench/rv_exec_tb.sv
module rv_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_exec_pkg::*;

    localparam int wait_limit = 50;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [xlen-1:0]       pwdata;
    logic [xlen-1:0]       prdata;
    logic                  pready;
    logic                  pslverr;
    logic [31:0]           lfsr;

    rv_exec_top rv_exec_top_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic logic [31:0] b_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'd0, rs2, rs1, f3, 5'd0, opc_branch};
    endfunction

    // starts in the cycle it is called, returns one step after the completing edge
    task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                                input logic [xlen-1:0] data);
        int cycles;
        cycles  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            cycles++;
            if (cycles > wait_limit) begin
                $display("pready stayed low too long on an access to address %h", addr);
                $display("RESULT: FAIL");
                $fatal(1, "APB access timed out");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic issue(input logic [31:0] word);
        apb_transfer(1'b1, addr_instr, word);
    endtask

    task automatic read_reg(input logic [4:0] n);
        apb_transfer(1'b0, addr_reg_base + {5'd0, n, 2'b00}, '0);
    endtask

    task automatic read_status();
        apb_transfer(1'b0, addr_status, '0);
    endtask

    // first assertion failure ends the run
    always @(negedge clk) begin
        if (rv_exec_top_inst.rv_exec_assertions_inst.fail_count != 0) begin
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure in the bound checker");
        end
    end

    initial begin
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [1:0]  kind;
        lfsr    = 32'hb368_0711;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        read_status();
        read_reg(5'd0);
        read_reg(5'd9);

        // random operands in x1..x15
        for (int n = 1; n < 16; n++) begin
            issue(i_instr(12'(rand_bits(12)), 5'd0, 3'd0, 5'(n)));
            issue(i_instr({7'd0, 5'(rand_bits(5))}, 5'(n), 3'd1, 5'(n)));
            issue(i_instr(12'(rand_bits(12)), 5'(n), 3'd4, 5'(n)));
        end

        for (int k = 0; k < 300; k++) begin
            kind = 2'(rand_bits(2));
            rd   = 5'(rand_bits(4));
            rs1  = 5'(rand_bits(4));
            rs2  = 5'(rand_bits(4));
            f3   = 3'(rand_bits(3));
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? f7_alt : f7_base;
            if (kind == 2'd0) begin
                issue(r_instr(f7, rs2, rs1, f3, rd));
            end else if (kind != 2'd3) begin
                imm = 12'(rand_bits(12));
                if (f3 == 3'd1) begin
                    imm = {f7_base, imm[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {f7, imm[4:0]};
                end
                issue(i_instr(imm, rs1, f3, rd));
            end else begin
                if (rand_bits(2) == 0) begin
                    rs2 = rs1;
                end
                issue(b_instr({2'b00, 1'(rand_bits(1))}, rs1, rs2));
                read_status();
            end
            if (rand_bits(2) == 0) begin
                read_reg(5'(rand_bits(4)));
            end
        end
        for (int n = 0; n < 32; n++) begin
            read_reg(5'(n));
        end

        // unsupported encodings
        issue(32'h0000_0073);
        issue(r_instr(7'b0000001, 5'd2, 5'd1, 3'd0, 5'd3));
        issue(i_instr({7'b0000001, 5'd3}, 5'd4, 3'd1, 5'd4));
        issue(b_instr(3'd4, 5'd1, 5'd2));
        read_status();
        for (int n = 0; n < 16; n++) begin
            read_reg(5'(n));
        end
        apb_transfer(1'b1, addr_status, 32'h0000_0004);
        read_status();

        // error responses and one clean status write
        apb_transfer(1'b1, addr_reg_base + 12'h004, 32'h1234_5678);
        apb_transfer(1'b0, addr_instr, '0);
        apb_transfer(1'b0, 12'h008, '0);
        apb_transfer(1'b0, 12'h100, '0);
        apb_transfer(1'b1, 12'h3fc, 32'hdead_beef);
        apb_transfer(1'b0, 12'h082, '0);
        apb_transfer(1'b1, addr_status, '0);
        read_status();

        repeat (2) @(negedge clk);
        if (rv_exec_top_inst.rv_exec_assertions_inst.fail_count != 0) begin
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure in the bound checker");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
